//--- source/cuPkg.sv
package cuPkg;

	// Instruction word and status flags
	localparam int WordWidth = 32;
	localparam int FlagWidth = 4;
	localparam int OperandWidth = WordWidth - 12;

	// Positions inside the flags vector
	localparam int NFlag = 3;
	localparam int ZFlag = 2;
	localparam int CFlag = 1;
	localparam int VFlag = 0;

	// Instruction classes
	localparam int ClassWidth = 3;
	localparam logic [ClassWidth-1:0] ClassDpImm = 3'd0;
	localparam logic [ClassWidth-1:0] ClassDpShift = 3'd1;
	localparam logic [ClassWidth-1:0] ClassLdst = 3'd2;
	localparam logic [ClassWidth-1:0] ClassMisc = 3'd3;
	localparam logic [ClassWidth-1:0] ClassBranch = 3'd4;
	localparam logic [ClassWidth-1:0] ClassBranchLink = 3'd5;
	localparam logic [ClassWidth-1:0] ClassUndef = 3'd6;

	// Memory access sizes
	localparam int SizeWidth = 2;
	localparam logic [SizeWidth-1:0] SizeByte = 2'd0;
	localparam logic [SizeWidth-1:0] SizeHalf = 2'd1;
	localparam logic [SizeWidth-1:0] SizeWord = 2'd2;
	localparam logic [SizeWidth-1:0] SizeNone = 2'd3;

	// Data-processing and branch view
	// Bit 24 is the link bit for branches, top opcode bit otherwise
	typedef struct packed {
		logic [3:0] cond;
		logic [2:0] format;
		logic link;
		logic [3:0] opBits;
		logic [OperandWidth-1:0] operand;
	} dpView_t;

	// Load/store view
	typedef struct packed {
		logic [3:0] cond;
		logic [2:0] format;
		logic p;
		logic u;
		logic b;
		logic w;
		logic l;
		logic [3:0] rn;
		logic [3:0] rd;
		logic [3:0] offsetHigh;
		logic bit7;
		logic [1:0] sh;
		logic bit4;
		logic [3:0] offsetLow;
	} xferView_t;

	typedef union packed {
		dpView_t dp;
		xferView_t xfer;
	} instrWord_t;

endpackage

//--- source/condIf.sv
`timescale 1ns/1ps

interface condIf;
	import cuPkg::*;

	logic valid;
	logic ready;
	instrWord_t word;
	// Condition result against the flags at acceptance
	logic passed;

	modport producer (
		output valid, word, passed,
		input ready
	);

	modport consumer (
		input valid, word, passed,
		output ready
	);
endinterface

//--- source/decodeIf.sv
`timescale 1ns/1ps

interface decodeIf;
	import cuPkg::*;

	logic valid;
	logic ready;
	logic [ClassWidth-1:0] instrClass;
	logic passed;
	// Access fields, only meaningful for Ldst and Misc
	logic load;
	logic [SizeWidth-1:0] size;
	logic signedLoad;
	logic writeBack;

	modport producer (
		output valid, instrClass, passed, load, size, signedLoad, writeBack,
		input ready
	);

	modport consumer (
		input valid, instrClass, passed, load, size, signedLoad, writeBack,
		output ready
	);
endinterface

//--- source/condCheck.sv
`timescale 1ns/1ps

module condCheck (
	input  logic clk,
	input  logic clr,
	input  logic inValid,
	output logic inReady,
	input  cuPkg::instrWord_t instruction,
	input  logic [cuPkg::FlagWidth-1:0] flags,
	condIf.producer out
);
	import cuPkg::*;

	logic flagN;
	logic flagZ;
	logic flagC;
	logic flagV;
	logic condMet;
	logic accept;

	assign flagN = flags[NFlag];
	assign flagZ = flags[ZFlag];
	assign flagC = flags[CFlag];
	assign flagV = flags[VFlag];

	// One-entry stage, refills in the cycle it drains
	assign inReady = !out.valid || out.ready;
	assign accept = inValid && inReady;

	always_comb
	begin
		case (instruction.dp.cond)
			4'h0: condMet = flagZ;
			4'h1: condMet = !flagZ;
			4'h2: condMet = flagC;
			4'h3: condMet = !flagC;
			4'h4: condMet = flagN;
			4'h5: condMet = !flagN;
			4'h6: condMet = flagV;
			4'h7: condMet = !flagV;
			4'h8: condMet = flagC && !flagZ;
			4'h9: condMet = !flagC || flagZ;
			4'hA: condMet = (flagN == flagV);
			4'hB: condMet = (flagN != flagV);
			4'hC: condMet = !flagZ && (flagN == flagV);
			4'hD: condMet = flagZ || (flagN != flagV);
			4'hE: condMet = 1'b1;
			// Code 15 is never taken
			default: condMet = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge clr)
	begin
		if (!clr)
			out.valid <= 1'b0;
		else if (accept)
			out.valid <= 1'b1;
		else if (out.ready)
			out.valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			out.word <= instruction;
			out.passed <= condMet;
		end
	end
endmodule

//--- source/instrDecode.sv
`timescale 1ns/1ps

module instrDecode (
	input  logic clk,
	input  logic clr,
	condIf.consumer in,
	decodeIf.producer out
);
	import cuPkg::*;

	logic [ClassWidth-1:0] instrClass;
	logic load;
	logic [SizeWidth-1:0] size;
	logic signedLoad;
	logic writeBack;
	logic regOffsetClean;
	logic accept;

	assign in.ready = !out.valid || out.ready;
	assign accept = in.valid && in.ready;

	// Register offset form needs bits 11:4 all zero
	assign regOffsetClean = (in.word.xfer.offsetHigh == 4'h0) && !in.word.xfer.bit7
		&& (in.word.xfer.sh == 2'b00) && !in.word.xfer.bit4;

	// Class from the format bits
	always_comb
	begin
		instrClass = ClassUndef;
		case (in.word.dp.format)
			3'b001: instrClass = ClassDpImm;
			3'b000:
				if (!in.word.xfer.bit4)
					instrClass = ClassDpShift;
				else if (in.word.xfer.bit7 && (in.word.xfer.sh != 2'b00))
					instrClass = ClassMisc;
			3'b010: instrClass = ClassLdst;
			3'b011:
				if (regOffsetClean)
					instrClass = ClassLdst;
			3'b101: instrClass = in.word.dp.link ? ClassBranchLink : ClassBranch;
			default: instrClass = ClassUndef;
		endcase
	end

	// Access fields through the transfer view
	always_comb
	begin
		load = 1'b0;
		size = SizeNone;
		signedLoad = 1'b0;
		writeBack = 1'b0;
		if (instrClass == ClassLdst || instrClass == ClassMisc)
		begin
			load = in.word.xfer.l;
			// Post-indexed always writes the base back
			writeBack = !in.word.xfer.p || in.word.xfer.w;
		end
		if (instrClass == ClassLdst)
			size = in.word.xfer.b ? SizeByte : SizeWord;
		else if (instrClass == ClassMisc)
		begin
			size = SizeHalf;
			if (in.word.xfer.l)
			begin
				signedLoad = in.word.xfer.sh[1];
				if (in.word.xfer.sh == 2'b10)
					size = SizeByte;
			end
		end
	end

	always_ff @(posedge clk or negedge clr)
	begin
		if (!clr)
			out.valid <= 1'b0;
		else if (accept)
			out.valid <= 1'b1;
		else if (out.ready)
			out.valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			out.instrClass <= instrClass;
			out.passed <= in.passed;
			out.load <= load;
			out.size <= size;
			out.signedLoad <= signedLoad;
			out.writeBack <= writeBack;
		end
	end
endmodule

//--- source/stepSequencer.sv
`timescale 1ns/1ps

module stepSequencer #(
	parameter int ExecSteps = 2
) (
	input  logic clk,
	input  logic clr,
	decodeIf.consumer in,
	output logic memEn,
	output logic memRW,
	input  logic mfc,
	output logic resultValid,
	input  logic resultReady,
	output logic [cuPkg::ClassWidth-1:0] resultClass,
	output logic resultExecuted,
	output logic resultLoad,
	output logic resultSigned,
	output logic resultWriteBack,
	output logic [cuPkg::SizeWidth-1:0] resultSize
);
	import cuPkg::*;

	localparam int StepWidth = (ExecSteps > 1) ? $clog2(ExecSteps) : 1;
	localparam logic [1:0] PhaseIdle = 2'd0;
	localparam logic [1:0] PhaseExec = 2'd1;
	localparam logic [1:0] PhaseMem = 2'd2;
	localparam logic [1:0] PhaseDone = 2'd3;

	logic [1:0] phase;
	logic [StepWidth-1:0] stepCount;
	logic accept;
	logic isMem;
	logic [ClassWidth-1:0] classReg;
	logic passedReg;
	logic loadReg;
	logic [SizeWidth-1:0] sizeReg;
	logic signedReg;
	logic writeBackReg;

	// A new item may enter while the finished one is taken
	assign in.ready = (phase == PhaseIdle) || (phase == PhaseDone && resultReady);
	assign accept = in.valid && in.ready;
	assign isMem = (classReg == ClassLdst) || (classReg == ClassMisc);

	always_ff @(posedge clk or negedge clr)
	begin
		if (!clr)
		begin
			phase <= PhaseIdle;
			stepCount <= '0;
		end
		else if (accept)
		begin
			phase <= PhaseExec;
			// Failed condition costs one cycle
			stepCount <= in.passed ? StepWidth'(ExecSteps - 1) : '0;
		end
		else
		begin
			case (phase)
				PhaseExec:
					if (stepCount != '0)
						stepCount <= stepCount - 1'b1;
					else if (passedReg && isMem)
						phase <= PhaseMem;
					else
						phase <= PhaseDone;
				PhaseMem:
					if (mfc)
						phase <= PhaseDone;
				PhaseDone:
					if (resultReady)
						phase <= PhaseIdle;
				default: phase <= PhaseIdle;
			endcase
		end
	end

	// Held from accept to the end of the result handshake
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			classReg <= in.instrClass;
			passedReg <= in.passed;
			loadReg <= in.load;
			sizeReg <= in.size;
			signedReg <= in.signedLoad;
			writeBackReg <= in.writeBack;
		end
	end

	assign memEn = (phase == PhaseMem);
	assign memRW = loadReg;
	assign resultValid = (phase == PhaseDone);
	assign resultClass = classReg;
	assign resultExecuted = passedReg;
	assign resultLoad = loadReg;
	assign resultSize = sizeReg;
	assign resultSigned = signedReg;
	assign resultWriteBack = writeBackReg;
endmodule

//--- source/controlUnit.sv
`timescale 1ns/1ps

module controlUnit #(
	parameter int ExecSteps = 2
) (
	input  logic clk,
	input  logic clr,
	input  logic inValid,
	output logic inReady,
	input  logic [cuPkg::WordWidth-1:0] instruction,
	input  logic [cuPkg::FlagWidth-1:0] flags,
	output logic memEn,
	output logic memRW,
	input  logic mfc,
	output logic resultValid,
	input  logic resultReady,
	output logic [cuPkg::ClassWidth-1:0] resultClass,
	output logic resultExecuted,
	output logic resultLoad,
	output logic [cuPkg::SizeWidth-1:0] resultSize,
	output logic resultSigned,
	output logic resultWriteBack
);
	// Stage one to stage two
	condIf condBus ();
	// Stage two to stage three
	decodeIf decodeBus ();

	condCheck u_condCheck (
		.clk(clk),
		.clr(clr),
		.inValid(inValid),
		.inReady(inReady),
		.instruction(instruction),
		.flags(flags),
		.out(condBus)
	);

	instrDecode u_instrDecode (
		.clk(clk),
		.clr(clr),
		.in(condBus),
		.out(decodeBus)
	);

	stepSequencer #(
		.ExecSteps(ExecSteps)
	) u_stepSequencer (
		.clk(clk),
		.clr(clr),
		.in(decodeBus),
		.memEn(memEn),
		.memRW(memRW),
		.mfc(mfc),
		.resultValid(resultValid),
		.resultReady(resultReady),
		.resultClass(resultClass),
		.resultExecuted(resultExecuted),
		.resultLoad(resultLoad),
		.resultSigned(resultSigned),
		.resultWriteBack(resultWriteBack),
		.resultSize(resultSize)
	);
endmodule

//--- tests/controlUnitTb.sv
`timescale 1ns/1ps

module controlUnitTb;
	import cuPkg::*;

	localparam int NumVectors = 30;
	localparam int Fields = 8;
	localparam int TimeoutCycles = NumVectors * 40 + 50;

	logic clk = 1'b0;
	logic clr;
	logic inValid;
	logic inReady;
	logic [WordWidth-1:0] instruction;
	logic [FlagWidth-1:0] flags;
	logic memEn;
	logic memRW;
	logic mfc;
	logic resultValid;
	logic resultReady;
	logic [ClassWidth-1:0] resultClass;
	logic resultExecuted;
	logic resultLoad;
	logic [SizeWidth-1:0] resultSize;
	logic resultSigned;
	logic resultWriteBack;

	// Eight hex columns per vector in the data file
	logic [31:0] vectors [0:NumVectors*Fields-1];
	int pending [$];
	int resultCount = 0;
	int memCount = 0;
	int memDelay = 0;
	int unsigned seedValue;
	logic memEnPrev = 1'b0;
	logic memRWPrev = 1'b0;
	logic mfcPrev = 1'b0;
	logic waitingPrev = 1'b0;
	logic [8:0] fieldsPrev = '0;
	logic [8:0] resultFields;

	assign resultFields = {resultClass, resultExecuted, resultLoad, resultSize, resultSigned,
		resultWriteBack};

	controlUnit #(
		.ExecSteps(2)
	) u_controlUnit (
		.clk(clk),
		.clr(clr),
		.inValid(inValid),
		.inReady(inReady),
		.instruction(instruction),
		.flags(flags),
		.memEn(memEn),
		.memRW(memRW),
		.mfc(mfc),
		.resultValid(resultValid),
		.resultReady(resultReady),
		.resultClass(resultClass),
		.resultExecuted(resultExecuted),
		.resultLoad(resultLoad),
		.resultSize(resultSize),
		.resultSigned(resultSigned),
		.resultWriteBack(resultWriteBack)
	);

	always #50 clk = ~clk;

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic checkBit(input string name, input logic got, input logic expected);
		if (got !== expected)
		begin
			$display("error %s: got 0x%h, expected 0x%h", name, got, expected);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic checkClass(input string name, input logic [ClassWidth-1:0] got,
		input logic [ClassWidth-1:0] expected);
		if (got !== expected)
		begin
			$display("error %s: got 0x%h, expected 0x%h", name, got, expected);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic checkSize(input string name, input logic [SizeWidth-1:0] got,
		input logic [SizeWidth-1:0] expected);
		if (got !== expected)
		begin
			$display("error %s: got 0x%h, expected 0x%h", name, got, expected);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic checkIdle();
		checkBit("memEn", memEn, 1'b0);
		checkBit("resultValid", resultValid, 1'b0);
		checkBit("inReady", inReady, 1'b1);
	endtask

	// Oldest outstanding vector owns the result being handed over
	task automatic takeResult();
		int base;
		logic executed;
		logic [ClassWidth-1:0] expClass;
		logic memExpected;
		if (pending.size() == 0)
			failRun("a result arrived with no instruction outstanding");
		else
		begin
			base = pending.pop_front() * Fields;
			expClass = vectors[base+2][ClassWidth-1:0];
			executed = vectors[base+3][0];
			checkClass("resultClass", resultClass, expClass);
			checkBit("resultExecuted", resultExecuted, executed);
			if (executed)
			begin
				checkBit("resultLoad", resultLoad, vectors[base+4][0]);
				checkSize("resultSize", resultSize, vectors[base+5][SizeWidth-1:0]);
				checkBit("resultSigned", resultSigned, vectors[base+6][0]);
				checkBit("resultWriteBack", resultWriteBack, vectors[base+7][0]);
			end
			memExpected = executed && (expClass == ClassLdst || expClass == ClassMisc);
			if (memCount != int'(memExpected))
				failRun("an instruction raised the wrong number of memory strobes");
			memCount = 0;
			resultCount++;
		end
	endtask

	// Random memory and result consumer
	initial
	begin
		mfc = 1'b0;
		resultReady = 1'b0;
		seedValue = $urandom(75);
		forever
		begin
			@(posedge clk);
			#1;
			resultReady = $urandom % 2;
			if (mfc || !memEn)
			begin
				mfc = 1'b0;
				memDelay = $urandom % 4;
			end
			else if (memDelay == 0)
				mfc = 1'b1;
			else
				memDelay = memDelay - 1;
		end
	end

	// Sampled mid-cycle where the next edge sees the same values
	always @(negedge clk)
	begin
		if (clr)
		begin
			if (memEn && !memEnPrev)
			begin
				if (pending.size() == 0)
					failRun("memory strobe raised with no instruction in flight");
				else
					checkBit("memRW", memRW, vectors[pending[0]*Fields+4][0]);
				memCount++;
			end
			if (memEnPrev && memEn && memRW !== memRWPrev)
				failRun("memRW changed while the memory strobe was high");
			if (memEnPrev && !memEn && !mfcPrev)
				failRun("memory strobe dropped before mfc arrived");
			if (waitingPrev && (!resultValid || resultFields !== fieldsPrev))
				failRun("result changed before resultReady took it");
			if (resultValid && resultReady)
				takeResult();
			memEnPrev = memEn;
			memRWPrev = memRW;
			mfcPrev = mfc;
			waitingPrev = resultValid && !resultReady;
			fieldsPrev = resultFields;
		end
	end

	initial
	begin
		repeat (TimeoutCycles) @(posedge clk);
		$display("results stopped arriving within %0d cycles", TimeoutCycles);
		$display("Test failed");
		$fatal(1);
	end

	initial
	begin
		logic accepted;
		clr = 1'b0;
		inValid = 1'b0;
		instruction = '0;
		flags = '0;
		$readmemh("tests/controlUnitInput.txt", vectors);
		@(negedge clk);
		checkIdle();
		@(posedge clk);
		#1;
		clr = 1'b1;
		@(negedge clk);
		checkIdle();
		@(posedge clk);
		#1;
		for (int i = 0; i < NumVectors; i++)
		begin
			inValid = 1'b1;
			instruction = vectors[i*Fields];
			flags = vectors[i*Fields+1][FlagWidth-1:0];
			accepted = 1'b0;
			while (!accepted)
			begin
				@(negedge clk);
				accepted = inReady;
				@(posedge clk);
				#1;
			end
			pending.push_back(i);
		end
		inValid = 1'b0;
		wait (resultCount == NumVectors);
		@(negedge clk);
		$display("Test passed");
		$finish;
	end
endmodule

//--- tests/controlUnitInput.txt
// instruction flags(NZCV) class executed load size signed writeBack
// one vector per line, every field in hex
03A01005 4 0 1 0 3 0 0
11A01002 4 1 0 0 3 0 0
25921004 2 2 1 1 2 0 0
35821004 2 2 0 0 2 0 0
44C21001 8 2 1 0 0 0 1
5A000010 8 4 0 0 3 0 0
6B000010 1 5 1 0 3 0 0
71D210B2 1 3 0 1 1 0 0
87F21003 2 2 1 1 0 0 1
98920006 2 6 0 0 3 0 0
A0D210D2 9 3 1 1 0 1 1
B3A01005 9 0 0 0 3 0 0
C1F210F2 0 3 1 1 1 1 1
D7921013 0 6 0 0 3 0 0
E0C210B2 F 3 1 0 1 0 1
F1A01002 F 1 0 0 3 0 0
01A01112 0 6 0 0 3 0 0
11C210F2 0 3 1 0 1 0 0
2A000010 0 4 0 0 3 0 0
34521001 0 2 1 1 0 0 1
40000091 0 6 0 0 3 0 0
5B000001 0 5 1 0 3 0 0
63A01005 0 0 0 0 3 0 0
71A01062 0 1 1 0 3 0 0
80000091 6 6 0 0 3 0 0
96821003 4 2 1 0 2 0 1
AA000010 8 4 0 0 3 0 0
B0D210B2 8 3 1 1 1 0 1
C2811001 4 0 0 0 3 0 0
D3A01005 1 0 1 0 3 0 0

//--- sources.f
source/cuPkg.sv
source/condIf.sv
source/decodeIf.sv
source/condCheck.sv
source/instrDecode.sv
source/stepSequencer.sv
source/controlUnit.sv
tests/controlUnitTb.sv

//--- Bender.yml
package:
  name: control_unit

sources:
  - source/cuPkg.sv
  - source/condIf.sv
  - source/decodeIf.sv
  - source/condCheck.sv
  - source/instrDecode.sv
  - source/stepSequencer.sv
  - source/controlUnit.sv
  - target: test
    files:
      - tests/controlUnitTb.sv
